/* rtl/video_pkg.sv */
/*
 * shared types for the tile video subsystem
 * axi4-lite bundles, raster and pixel buses, cpu register map
 * modules import it in their body and use scoped names in port lists
 */
package video_pkg;

    // cpu side, master to slave
    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // cpu side, slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

    // scan position, lhbl/lvbl high in the active area
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
    } raster_t;

    // scroll_x counts 8-pixel words
    typedef struct packed {
        logic [5:0] scroll_x;
        logic [7:0] scroll_y;
        logic       layer_en;
    } video_cfg_t;

    // rgb555, red in the top bits
    typedef struct packed {
        logic        we;
        logic [3:0]  idx;
        logic [14:0] rgb;
    } pal_wr_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       de;
    } pixel_t;

    // eight 4bpp pixels per word, pixel 0 in the low nibble
    typedef struct packed {
        logic        we;
        logic [5:0]  addr;
        logic [31:0] data;
    } lb_wr_t;

    // register map
    localparam logic [7:0] REG_SCROLL_X = 8'h00;
    localparam logic [7:0] REG_SCROLL_Y = 8'h04;
    localparam logic [7:0] REG_CTRL     = 8'h08;
    localparam logic [7:0] REG_IRQ      = 8'h0C;
    // 16 entries, one per word up to 0x7c
    localparam logic [7:0] PAL_BASE     = 8'h40;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

endpackage

/* rtl/video_timing.sv */
/*
 * raster timing generator
 * scan counters, blanking, sync and the render line, all registered
 * so every block downstream sees the same line start
 */
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 320,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262
) (
    input  logic               clk,
    input  logic               rst,
    output video_pkg::raster_t raster
);
    localparam logic [8:0] H_LAST = 9'(H_TOTAL - 1);
    localparam logic [8:0] V_LAST = 9'(V_TOTAL - 1);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    // next scan position
    always_comb begin
        h_nxt = raster.hdump + 9'd1;
        v_nxt = raster.vdump;
        if (raster.hdump == H_LAST) begin
            h_nxt = '0;
            v_nxt = (raster.vdump == V_LAST) ? '0 : raster.vdump + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            raster.hdump   <= '0;
            raster.vdump   <= '0;
            raster.vrender <= 9'd1;
            raster.lhbl    <= 1'b1;
            raster.lvbl    <= 1'b1;
            raster.hs      <= 1'b0;
            raster.vs      <= 1'b0;
        end else begin
            raster.hdump   <= h_nxt;
            raster.vdump   <= v_nxt;
            // line being fetched, one ahead of the displayed one
            raster.vrender <= (v_nxt == V_LAST) ? '0 : v_nxt + 9'd1;
            raster.lhbl    <= h_nxt < 9'(H_ACTIVE);
            raster.lvbl    <= v_nxt < 9'(V_ACTIVE);
            // 4 counts right after the active area
            raster.hs      <= (h_nxt >= 9'(H_ACTIVE)) && (h_nxt < 9'(H_ACTIVE + 4));
            raster.vs      <= v_nxt == 9'(V_ACTIVE + 1);
        end
    end

endmodule

/* rtl/video_regs.sv */
/*
 * axi4-lite slave for the video registers
 * scroll, layer enable and vblank irq live here, palette accesses are
 * forwarded to the ram in the color mixer
 */
`timescale 1ns/1ps

module video_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  video_pkg::axil_req_t  axil_req,
    output video_pkg::axil_rsp_t  axil_rsp,
    input  video_pkg::raster_t    raster,
    output video_pkg::video_cfg_t cfg,
    output video_pkg::pal_wr_t    pal_wr,
    output logic [3:0]            pal_rd_idx,
    input  logic [14:0]           pal_rd_data,
    output logic                  irq
);
    import video_pkg::*;

    logic        awready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        ar_pend;
    logic        rvalid;
    logic [7:0]  ar_addr;
    logic [31:0] rdata;
    logic        wr_hs;
    logic        wr_ok;
    logic        rd_ok;
    logic        lvbl_q;

    // four control words plus the palette window
    function automatic logic addr_ok(input logic [7:0] a);
        return (a == REG_SCROLL_X) || (a == REG_SCROLL_Y) || (a == REG_CTRL) ||
               (a == REG_IRQ) || ((a[7:6] == PAL_BASE[7:6]) && (a[1:0] == 2'b00));
    endfunction

    assign wr_hs = awready && axil_req.awvalid && axil_req.wvalid;
    assign wr_ok = addr_ok(axil_req.awaddr);
    assign rd_ok = addr_ok(ar_addr);

    // palette write goes straight through on the handshake
    assign pal_wr = '{we:  wr_hs && wr_ok && axil_req.awaddr[6],
                      idx: axil_req.awaddr[5:2],
                      rgb: axil_req.wdata[14:0]};

    // aw and w are taken together, one response outstanding
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            cfg     <= '0;
            irq     <= 1'b0;
            lvbl_q  <= 1'b1;
        end else begin
            awready <= axil_req.awvalid && axil_req.wvalid && !awready && !bvalid;
            lvbl_q  <= raster.lvbl;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                case (axil_req.awaddr)
                    REG_SCROLL_X: cfg.scroll_x <= axil_req.wdata[5:0];
                    REG_SCROLL_Y: cfg.scroll_y <= axil_req.wdata[7:0];
                    REG_CTRL:     cfg.layer_en <= axil_req.wdata[0];
                    // write one to acknowledge
                    REG_IRQ:      if (axil_req.wdata[0]) irq <= 1'b0;
                    default: ;
                endcase
            end else if (bvalid && axil_req.bready) begin
                bvalid <= 1'b0;
            end
            // vblank entry wins over a same-cycle clear
            if (lvbl_q && !raster.lvbl) irq <= 1'b1;
        end
    end

    // read: handshake, palette ram cycle, then rvalid
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            ar_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= axil_req.arvalid && !arready && !ar_pend && !rvalid;
            if (arready && axil_req.arvalid) begin
                ar_pend <= 1'b1;
            end else if (ar_pend) begin
                ar_pend <= 1'b0;
                rvalid  <= 1'b1;
            end else if (rvalid && axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arready && axil_req.arvalid) ar_addr <= axil_req.araddr;
    end

    // held address keeps the palette data stable while rvalid waits
    assign pal_rd_idx = ar_addr[5:2];

    always_comb begin
        rdata = '0;
        case (ar_addr)
            REG_SCROLL_X: rdata[5:0] = cfg.scroll_x;
            REG_SCROLL_Y: rdata[7:0] = cfg.scroll_y;
            REG_CTRL:     rdata[0]   = cfg.layer_en;
            REG_IRQ:      rdata[0]   = irq;
            default:      if (rd_ok) rdata[14:0] = pal_rd_data;
        endcase
    end

    assign axil_rsp = '{awready: awready,
                        wready:  awready,
                        bresp:   bresp,
                        bvalid:  bvalid,
                        arready: arready,
                        rdata:   rdata,
                        rresp:   rd_ok ? RESP_OKAY : RESP_SLVERR,
                        rvalid:  rvalid};

endmodule

/* rtl/tile_fetch.sv */
/*
 * background line fetcher
 * reads one scroll-adjusted bitmap line per scan line from the gfx rom
 * and writes it word by word into the line buffer
 */
`timescale 1ns/1ps

module tile_fetch #(
    parameter int H_ACTIVE = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  video_pkg::raster_t    raster,
    input  video_pkg::video_cfg_t cfg,
    output logic                  rom_cs,
    output logic [13:0]           rom_addr,
    input  logic [31:0]           rom_data,
    input  logic                  rom_ok,
    output video_pkg::lb_wr_t     lb_wr
);
    localparam logic [5:0] LAST_WORD = 6'(H_ACTIVE / 8 - 1);

    logic       line_start;
    logic [5:0] word;
    logic [7:0] row;
    logic [5:0] col;

    assign line_start = raster.hdump == '0;

    // bitmap is 256 rows of 64 words, both axes wrap
    assign col      = word + cfg.scroll_x;
    assign rom_addr = {row, col};

    // rom_cs is the request state, busy from line start to the last word
    always_ff @(posedge clk) begin
        if (rst) begin
            rom_cs <= 1'b0;
            word   <= '0;
        end else if (line_start) begin
            // anything left of the old line is dropped
            rom_cs <= 1'b1;
            word   <= '0;
        end else if (rom_cs && rom_ok) begin
            word <= word + 6'd1;
            if (word == LAST_WORD) rom_cs <= 1'b0;
        end
    end

    // row for the line being rendered, fixed for the whole line
    always_ff @(posedge clk) begin
        if (line_start) row <= raster.vrender[7:0] + cfg.scroll_y;
    end

    // store in the cycle of rom_ok, slot is the display word
    assign lb_wr = '{we:   rom_cs && rom_ok,
                     addr: word,
                     data: rom_data};

endmodule

/* rtl/line_buffer.sv */
/*
 * double line buffer between fetcher and color mixer
 * one half is written while the other is shown, halves swap at
 * each line start; read returns one 4-bit pixel a cycle later
 */
`timescale 1ns/1ps

module line_buffer #(
    parameter int H_ACTIVE = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  video_pkg::raster_t raster,
    input  video_pkg::lb_wr_t  lb_wr,
    input  logic [8:0]         rd_addr,
    output logic [3:0]         rd_data
);
    localparam int WORDS = H_ACTIVE / 8;
    localparam int AW    = $clog2(WORDS);

    logic [31:0] mem [0:1][0:WORDS-1];
    logic        wr_bank;
    logic        rd_bank;
    logic        line_start;
    logic [31:0] rd_word;

    assign line_start = raster.hdump == '0;

    // bank flips at the end of the line start cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_bank <= 1'b0;
        end else if (line_start) begin
            wr_bank <= ~wr_bank;
        end
    end

    // pixel 0 is read before the flip lands, so look ahead
    assign rd_bank = line_start ? wr_bank : ~wr_bank;
    assign rd_word = mem[rd_bank][rd_addr[3 +: AW]];

    always_ff @(posedge clk) begin
        if (lb_wr.we) mem[wr_bank][lb_wr.addr[AW-1:0]] <= lb_wr.data;
        // nibble select by pixel x
        rd_data <= rd_word[{rd_addr[2:0], 2'b00} +: 4];
    end

endmodule

/* rtl/color_mix.sv */
/*
 * color mixer
 * palette lookup of the buffered pixel, rgb555 to 24-bit expansion
 * and blanking; output lags the raster by two cycles
 */
`timescale 1ns/1ps

module color_mix (
    input  logic                  clk,
    input  logic                  rst,
    input  video_pkg::raster_t    raster,
    input  video_pkg::video_cfg_t cfg,
    input  video_pkg::pal_wr_t    pal_wr,
    input  logic [3:0]            pal_rd_idx,
    output logic [14:0]           pal_rd_data,
    output logic [8:0]            rd_addr,
    input  logic [3:0]            rd_data,
    output video_pkg::pixel_t     pixel
);
    logic [14:0] pal [0:15];
    logic        de_d1;
    logic [3:0]  pal_idx;
    logic [14:0] rgb;

    // buffer read for the current position, data next cycle
    assign rd_addr = raster.hdump;

    // value 0 or a disabled layer shows the backdrop
    assign pal_idx = (cfg.layer_en && (rd_data != 4'd0)) ? rd_data : 4'd0;
    assign rgb     = pal[pal_idx];

    // palette ram, cpu write and registered cpu read
    always_ff @(posedge clk) begin
        if (pal_wr.we) pal[pal_wr.idx] <= pal_wr.rgb;
        pal_rd_data <= pal[pal_rd_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            de_d1 <= 1'b0;
            pixel <= '0;
        end else begin
            de_d1    <= raster.lhbl && raster.lvbl;
            pixel.de <= de_d1;
            if (de_d1) begin
                // 5 bits repeated into the low 3
                pixel.r <= {rgb[14:10], rgb[14:12]};
                pixel.g <= {rgb[9:5], rgb[9:7]};
                pixel.b <= {rgb[4:0], rgb[4:2]};
            end else begin
                pixel.r <= '0;
                pixel.g <= '0;
                pixel.b <= '0;
            end
        end
    end

endmodule

/* rtl/video_top.sv */
/*
 * tile video subsystem top
 * timing, cpu registers, rom fetcher, line buffer and color mixer;
 * geometry is set here and handed to the blocks that need it
 */
`timescale 1ns/1ps

module video_top #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 320,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 262
) (
    input  logic                 clk,
    input  logic                 rst,
    input  video_pkg::axil_req_t axil_req,
    output video_pkg::axil_rsp_t axil_rsp,
    output logic                 rom_cs,
    output logic [13:0]          rom_addr,
    input  logic [31:0]          rom_data,
    input  logic                 rom_ok,
    output video_pkg::pixel_t    pixel,
    output logic                 irq
);
    import video_pkg::*;

    raster_t    raster;
    video_cfg_t cfg;
    pal_wr_t    pal_wr;
    lb_wr_t     lb_wr;
    logic [3:0]  pal_rd_idx;
    logic [14:0] pal_rd_data;
    logic [8:0]  lb_rd_addr;
    logic [3:0]  lb_rd_data;

    video_timing #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_timing (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .raster ( raster )
    );

    // cpu side
    video_regs u_regs (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .axil_req    ( axil_req    ),
        .axil_rsp    ( axil_rsp    ),
        .raster      ( raster      ),
        .cfg         ( cfg         ),
        .pal_wr      ( pal_wr      ),
        .pal_rd_idx  ( pal_rd_idx  ),
        .pal_rd_data ( pal_rd_data ),
        .irq         ( irq         )
    );

    tile_fetch #(.H_ACTIVE(H_ACTIVE)) u_fetch (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .raster   ( raster   ),
        .cfg      ( cfg      ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .lb_wr    ( lb_wr    )
    );

    line_buffer #(.H_ACTIVE(H_ACTIVE)) u_lbuf (
        .clk     ( clk        ),
        .rst     ( rst        ),
        .raster  ( raster     ),
        .lb_wr   ( lb_wr      ),
        .rd_addr ( lb_rd_addr ),
        .rd_data ( lb_rd_data )
    );

    // final pixels
    color_mix u_colmix (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .raster      ( raster      ),
        .cfg         ( cfg         ),
        .pal_wr      ( pal_wr      ),
        .pal_rd_idx  ( pal_rd_idx  ),
        .pal_rd_data ( pal_rd_data ),
        .rd_addr     ( lb_rd_addr  ),
        .rd_data     ( lb_rd_data  ),
        .pixel       ( pixel       )
    );

endmodule

/* dv/video_tb.sv */
/*
 * directed testbench for the tile video subsystem
 * programs the registers over axi4-lite, models the gfx rom with a
 * random latency and checks every output cycle of whole frames
 */
`timescale 1ns/1ps

module video_tb;
    import video_pkg::*;

    localparam int H_ACTIVE    = 32;
    localparam int H_TOTAL     = 48;
    localparam int V_ACTIVE    = 8;
    localparam int V_TOTAL     = 12;
    localparam int FRAME       = H_TOTAL * V_TOTAL;
    localparam int AXI_TIMEOUT = 64;

    logic        clk;
    logic        rst;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic        rom_cs;
    logic [13:0] rom_addr;
    logic [31:0] rom_data;
    logic        rom_ok;
    pixel_t      pixel;
    logic        irq;

    integer      seed = 32'h465a_572c;
    logic [1:0]  rom_wait;
    // raster mirror, d2 is the position of the pixel now on the output
    int          h, v;
    int          h_d1, v_d1;
    int          h_d2, v_d2;
    // what the cpu side has written so far
    logic [31:0] cur_sx;
    logic [31:0] cur_sy;
    logic        cur_en;
    logic [14:0] pal_ref [0:15];

    video_top #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) dut0 (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .axil_req ( req      ),
        .axil_rsp ( rsp      ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .pixel    ( pixel    ),
        .irq      ( irq      )
    );

    always #2 clk = ~clk;

    // gfx rom content, nibble i of word a is a + i
    function automatic logic [31:0] rom_word(input logic [13:0] a);
        logic [31:0] w;
        for (int i = 0; i < 8; i++) w[4*i +: 4] = a[3:0] + 4'(i);
        return w;
    endfunction

    // rom model, ok after 1 to 3 cycles, one idle cycle between words
    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_wait <= '0;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;
        end else if (!rom_cs) begin
            rom_wait <= '0;
        end else if (rom_wait == 2'd0) begin
            rom_wait <= 2'($unsigned($random(seed)) % 3 + 1);
        end else if (rom_wait == 2'd1) begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(rom_addr);
            rom_wait <= '0;
        end else begin
            rom_wait <= rom_wait - 2'd1;
        end
    end

    // scan counters as the timing rules define them, plus 2-cycle history
    always @(posedge clk) begin
        if (rst) begin
            h    <= 0;
            v    <= 0;
            h_d1 <= H_ACTIVE;
            v_d1 <= 0;
            h_d2 <= H_ACTIVE;
            v_d2 <= 0;
        end else begin
            h_d1 <= h;
            v_d1 <= v;
            h_d2 <= h_d1;
            v_d2 <= v_d1;
            if (h == H_TOTAL - 1) begin
                h <= 0;
                v <= (v == V_TOTAL - 1) ? 0 : v + 1;
            end else begin
                h <= h + 1;
            end
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                               $time, name, got, exp));
    endtask

    task automatic check_rdata(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                               $time, name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
    endtask

    // aw and w presented together, bready held until the response
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        int n;
        @(posedge clk);
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hf;
        req.wvalid  <= 1'b1;
        req.bready  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > AXI_TIMEOUT) fail_run("write address and data never accepted");
            if (rsp.awready !== rsp.wready) fail_run("awready and wready not raised together");
        end while (!rsp.awready);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > AXI_TIMEOUT) fail_run("write response never arrived");
        end while (!rsp.bvalid);
        req.bready <= 1'b0;
        check_resp($sformatf("bresp@%02h", addr), rsp.bresp, exp_resp);
    endtask

    task automatic axil_read(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
        int n;
        @(posedge clk);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        req.rready  <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > AXI_TIMEOUT) fail_run("read address never accepted");
        end while (!rsp.arready);
        req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > AXI_TIMEOUT) fail_run("read data never arrived");
        end while (!rsp.rvalid);
        req.rready <= 1'b0;
        check_resp($sformatf("rresp@%02h", addr), rsp.rresp, exp_resp);
        check_rdata($sformatf("rdata@%02h", addr), rsp.rdata, exp_data);
    endtask

    // returns on the cycle the output shows pixel (0,0)
    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME) fail_run("no frame start seen on the output");
        end while (!(h_d2 == 0 && v_d2 == 0));
    endtask

    // irq is registered, so it shows one count after line V_ACTIVE begins
    task automatic wait_irq();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME) fail_run("irq never rose");
        end while (!irq);
        if (v != V_ACTIVE || h != 1)
            fail_run($sformatf("irq rose at line %0d count %0d, not at vblank start", v, h));
    endtask

    // expected output from the address rule, palette and blanking
    function automatic pixel_t expect_pixel(input int x, input int y);
        pixel_t      p;
        int          addr;
        logic [3:0]  nib;
        logic [14:0] c;
        p = '0;
        if (x < H_ACTIVE && y < V_ACTIVE) begin
            addr = ((y + cur_sy) % 256) * 64 + (x / 8 + cur_sx) % 64;
            nib  = 4'((addr + x % 8) % 16);
            c    = (cur_en && nib != 4'd0) ? pal_ref[nib] : pal_ref[0];
            p.r  = {c[14:10], c[14:12]};
            p.g  = {c[9:5], c[9:7]};
            p.b  = {c[4:0], c[4:2]};
            p.de = 1'b1;
        end
        return p;
    endfunction

    task automatic readback_all();
        int i;
        axil_read(REG_SCROLL_X, cur_sx, RESP_OKAY);
        axil_read(REG_SCROLL_Y, cur_sy, RESP_OKAY);
        axil_read(REG_CTRL, {31'd0, cur_en}, RESP_OKAY);
        for (i = 0; i < 16; i++) begin
            axil_read(8'(PAL_BASE + 4 * i), {17'd0, pal_ref[i]}, RESP_OKAY);
        end
    endtask

    // upper bits beyond each register width must read back as 0
    task automatic readback_test();
        int          i;
        logic [31:0] val;
        axil_write(REG_SCROLL_X, 32'hffff_ffe5, RESP_OKAY);
        cur_sx = 32'h25;
        axil_write(REG_SCROLL_Y, 32'h1234_56a7, RESP_OKAY);
        cur_sy = 32'ha7;
        axil_write(REG_CTRL, 32'h0000_0003, RESP_OKAY);
        cur_en = 1'b1;
        for (i = 0; i < 16; i++) begin
            val = $random(seed);
            axil_write(8'(PAL_BASE + 4 * i), val, RESP_OKAY);
            pal_ref[i] = val[14:0];
        end
        readback_all();
    endtask

    task automatic bad_addr_test();
        axil_write(8'h20, 32'hdead_beef, RESP_SLVERR);
        axil_read(8'h20, 32'h0, RESP_SLVERR);
        readback_all();
    endtask

    // one frame settles the fetch, the next one is checked cycle by cycle
    task automatic frame_test(input logic [5:0] sx, input logic [7:0] sy, input logic en);
        int i;
        int count;
        axil_write(REG_SCROLL_X, {26'd0, sx}, RESP_OKAY);
        axil_write(REG_SCROLL_Y, {24'd0, sy}, RESP_OKAY);
        axil_write(REG_CTRL, {31'd0, en}, RESP_OKAY);
        cur_sx = {26'd0, sx};
        cur_sy = {24'd0, sy};
        cur_en = en;
        wait_frame_start();
        wait_frame_start();
        count = 0;
        for (i = 0; i < FRAME; i++) begin
            if (pixel.de) begin
                count++;
                check_pixel($sformatf("pixel(%0d,%0d)", h_d2, v_d2), pixel,
                            expect_pixel(h_d2, v_d2));
            end else begin
                // blanked output carries no color
                check_pixel($sformatf("pixel(%0d,%0d)", h_d2, v_d2), pixel, '0);
            end
            @(negedge clk);
        end
        if (count != H_ACTIVE * V_ACTIVE)
            fail_run($sformatf("MISMATCH at %0t: de count got %0d expected %0d",
                               $time, count, H_ACTIVE * V_ACTIVE));
    endtask

    task automatic irq_test();
        // start at line 0, far from vblank
        wait_frame_start();
        axil_write(REG_IRQ, 32'h1, RESP_OKAY);
        axil_read(REG_IRQ, 32'h0, RESP_OKAY);
        wait_irq();
        axil_read(REG_IRQ, 32'h1, RESP_OKAY);
        // a zero write is no acknowledge
        axil_write(REG_IRQ, 32'h0, RESP_OKAY);
        wait_frame_start();
        if (!irq) fail_run("irq dropped without an acknowledge");
        axil_read(REG_IRQ, 32'h1, RESP_OKAY);
        axil_write(REG_IRQ, 32'h1, RESP_OKAY);
        axil_read(REG_IRQ, 32'h0, RESP_OKAY);
        if (irq) fail_run("irq still high after the acknowledge");
        // next rise must be the next vblank start
        wait_irq();
    endtask

    initial begin
        clk      = 1'b0;
        rst      <= 1'b1;
        req      <= '0;
        rom_ok   <= 1'b0;
        rom_data <= '0;
        cur_sx   = '0;
        cur_sy   = '0;
        cur_en   = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        readback_test();
        bad_addr_test();
        frame_test(6'd0, 8'd0, 1'b1);
        frame_test(6'd5, 8'd3, 1'b1);
        // both axes wrap
        frame_test(6'd63, 8'd250, 1'b1);
        // layer off, backdrop only
        frame_test(6'd7, 8'd9, 1'b0);
        irq_test();
        $display("test passed");
        $finish;
    end

endmodule

/* video_top.f */
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/video_regs.sv
rtl/tile_fetch.sv
rtl/line_buffer.sv
rtl/color_mix.sv
rtl/video_top.sv
dv/video_tb.sv

/* Makefile */
# verilator build and run of the tile video testbench

SRCS := $(shell cat video_top.f)

obj_dir/Vvideo_tb: video_top.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module video_tb -f video_top.f

.PHONY: run clean

run: obj_dir/Vvideo_tb
	@out="$$(./obj_dir/Vvideo_tb)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
